//--- source/scrub_settings.svh
// Scrubber project constants
//   channel count and DDR address width
//   scrub range and burst geometry
//   APB register map and control register fields
//   fixed ID words shown when debug is off

`ifndef SCRUB_SETTINGS_SVH
`define SCRUB_SETTINGS_SVH

// Memory side
`define NUM_DDR               4
`define DDR_ADDR_W            64
`define SCRB_MAX_ADDR         64'h0000_0000_0000_1FFF
`define SCRB_BURST_LEN_MINUS1 15
`define SCRB_BEAT_BYTES       64

// Register side
`define APB_ADDR_W            8
`define REG_CTL_OFS           8'h00
`define REG_STATUS_OFS        8'h04
`define CL_ID0                32'hF001_1D0F
`define CL_ID1                32'h1D51_FEDD

// Control register layout, enables sit in the low NUM_DDR bits
`define CTL_DBG_EN_BIT        31
`define CTL_DBG_SEL_LSB       28

`endif

//--- source/scrub_mem_pkg.sv
// Memory-side types of the scrubber
//   DDR byte address
//   one-bit-per-channel vector
//   scrubber state encoding

`include "scrub_settings.svh"

package scrub_mem_pkg;

   // Full DDR byte address
   typedef logic [`DDR_ADDR_W-1:0] ddr_addr_t;

   // Bit i belongs to channel i
   typedef logic [`NUM_DDR-1:0] ddr_chan_vec_t;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      REQ  = 2'd1,
      DONE = 2'd2
   } scrub_state_t;

endpackage

//--- source/scrub_reg_pkg.sv
// Register-side types of the scrubber
//   APB address
//   32-bit register word
//   debug channel select field

`include "scrub_settings.svh"

package scrub_reg_pkg;

   // APB byte address
   typedef logic [`APB_ADDR_W-1:0] apb_addr_t;

   // Control and status register data
   typedef logic [31:0] reg_word_t;

   // Channel shown on the ID outputs in debug mode
   typedef logic [2:0] dbg_sel_t;

endpackage

//--- source/scrub_ctrl_regs.sv
// APB slave of the scrubber
//   control register with channel enables and debug fields
//   read mux for control and status words
//   error response on unmapped offsets

`timescale 1ns/100ps

`include "scrub_settings.svh"

module scrub_ctrl_regs (
   input  logic                        clk,
   input  logic                        sync_rst_n,

   // APB slave
   input  scrub_reg_pkg::apb_addr_t    paddr,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  scrub_reg_pkg::reg_word_t    pwdata,
   output scrub_reg_pkg::reg_word_t    prdata,
   output logic                        pready,
   output logic                        pslverr,

   // From the status block
   input  scrub_reg_pkg::reg_word_t    status_word,

   // Control fields
   output scrub_mem_pkg::ddr_chan_vec_t scrub_en,
   output logic                        dbg_en,
   output scrub_reg_pkg::dbg_sel_t     dbg_sel
);

   localparam int DBG_SEL_W = $bits(scrub_reg_pkg::dbg_sel_t);

   scrub_reg_pkg::reg_word_t ctl_q;
   logic                     access;
   logic                     hit_ctl;
   logic                     hit_status;

   // ----------------------------------------
   // Access phase decode
   // ----------------------------------------

   assign access     = psel & penable;
   assign hit_ctl    = (paddr == `REG_CTL_OFS);
   assign hit_status = (paddr == `REG_STATUS_OFS);

   // No wait states
   assign pready = 1'b1;

   // Unmapped offset, read or write
   assign pslverr = access & ~(hit_ctl | hit_status);

   // ----------------------------------------
   // Control register
   // ----------------------------------------

   // Written at the end of the access phase
   always_ff @(posedge clk or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         ctl_q <= '0;
      end else if (access && pwrite && hit_ctl) begin
         ctl_q <= pwdata;
      end
   end

   // Status is read-only, a write to it is dropped without error
   always_comb begin
      prdata = '0;
      if (access && !pwrite) begin
         if (hit_ctl) begin
            prdata = ctl_q;
         end else if (hit_status) begin
            prdata = status_word;
         end
      end
   end

   // ----------------------------------------
   // Field split
   // ----------------------------------------

   assign scrub_en = ctl_q[`NUM_DDR-1:0];
   assign dbg_en   = ctl_q[`CTL_DBG_EN_BIT];
   assign dbg_sel  = ctl_q[`CTL_DBG_SEL_LSB +: DBG_SEL_W];

endmodule

//--- source/ddr_scrubber.sv
// Per-channel DDR scrubber
//   FSM walking one channel from address 0 to the scrub limit
//   one burst request per handshake
//   done flag and last accepted address for status

`timescale 1ns/100ps

`include "scrub_settings.svh"

module ddr_scrubber (
   input  logic                     clk,
   input  logic                     sync_rst_n,

   input  logic                     enable,
   input  logic                     ddr_ready,

   // Burst request to the memory
   output logic                     req_valid,
   output scrub_mem_pkg::ddr_addr_t req_addr,
   input  logic                     req_ready,

   // To the status block
   output logic                     done,
   output scrub_mem_pkg::ddr_addr_t cur_addr
);

   // Bytes covered by one burst
   localparam scrub_mem_pkg::ddr_addr_t BURST_BYTES =
      scrub_mem_pkg::ddr_addr_t'((`SCRB_BURST_LEN_MINUS1 + 1) * `SCRB_BEAT_BYTES);

   scrub_mem_pkg::scrub_state_t state;
   scrub_mem_pkg::ddr_addr_t    next_addr;
   logic                        accept;
   logic                        last_burst;

   assign accept     = req_valid & req_ready;
   assign next_addr  = req_addr + BURST_BYTES;
   assign last_burst = (next_addr > `SCRB_MAX_ADDR);

   // ----------------------------------------
   // Scrub FSM
   // ----------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state    <= scrub_mem_pkg::IDLE;
         req_addr <= '0;
         cur_addr <= '0;
      end else if (!enable) begin
         // Withdraws any pending request
         state <= scrub_mem_pkg::IDLE;
      end else begin
         case (state)
            scrub_mem_pkg::IDLE: begin
               if (ddr_ready) begin
                  state    <= scrub_mem_pkg::REQ;
                  req_addr <= '0;
               end
            end
            scrub_mem_pkg::REQ: begin
               // Address holds while the memory stalls
               if (accept) begin
                  cur_addr <= req_addr;
                  if (last_burst) begin
                     state <= scrub_mem_pkg::DONE;
                  end else begin
                     req_addr <= next_addr;
                  end
               end
            end
            scrub_mem_pkg::DONE: begin
               // Stays here until enable drops
               state <= scrub_mem_pkg::DONE;
            end
            default: begin
               state <= scrub_mem_pkg::IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------
   // Outputs decoded from state
   // ----------------------------------------

   assign req_valid = (state == scrub_mem_pkg::REQ);
   assign done      = (state == scrub_mem_pkg::DONE);

endmodule

//--- source/scrub_status.sv
// Scrubber status collection
//   registered status word with done and ready bits
//   ID outputs, fixed constants or selected channel address

`timescale 1ns/100ps

`include "scrub_settings.svh"

module scrub_status (
   input  logic                          clk,
   input  logic                          sync_rst_n,

   input  scrub_mem_pkg::ddr_chan_vec_t  done,
   input  scrub_mem_pkg::ddr_chan_vec_t  ddr_ready,
   input  scrub_mem_pkg::ddr_addr_t      cur_addr [`NUM_DDR],

   input  logic                          dbg_en,
   input  scrub_reg_pkg::dbg_sel_t       dbg_sel,

   output scrub_reg_pkg::reg_word_t      status_word,
   output scrub_reg_pkg::reg_word_t      cl_id0,
   output scrub_reg_pkg::reg_word_t      cl_id1
);

   localparam int CHAN_W = $clog2(`NUM_DDR);

   scrub_reg_pkg::reg_word_t status_next;
   scrub_mem_pkg::ddr_addr_t sel_addr;
   logic [CHAN_W-1:0]        sel_chan;

   // Done in the low bits, ready from bit 16 up
   always_comb begin
      status_next                 = '0;
      status_next[`NUM_DDR-1:0]   = done;
      status_next[16 +: `NUM_DDR] = ddr_ready;
   end

   // Out-of-range select falls back to channel 0
   always_comb begin
      if (dbg_sel < `NUM_DDR) begin
         sel_chan = CHAN_W'(dbg_sel);
      end else begin
         sel_chan = '0;
      end
   end

   assign sel_addr = cur_addr[sel_chan];

   always_ff @(posedge clk or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         status_word <= '0;
         cl_id0      <= `CL_ID0;
         cl_id1      <= `CL_ID1;
      end else begin
         status_word <= status_next;
         cl_id0      <= dbg_en ? sel_addr[31:0]  : `CL_ID0;
         cl_id1      <= dbg_en ? sel_addr[63:32] : `CL_ID1;
      end
   end

endmodule

//--- source/ddr_scrub_top.sv
// Top level of the DDR scrubber
//   APB control register block
//   one scrubber per DDR channel
//   status and debug ID block

`timescale 1ns/100ps

`include "scrub_settings.svh"

module ddr_scrub_top (
   input  logic                         clk,
   input  logic                         sync_rst_n,

   // APB slave
   input  scrub_reg_pkg::apb_addr_t     paddr,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  scrub_reg_pkg::reg_word_t     pwdata,
   output scrub_reg_pkg::reg_word_t     prdata,
   output logic                         pready,
   output logic                         pslverr,

   // Memory side, one lane per channel
   input  scrub_mem_pkg::ddr_chan_vec_t ddr_is_ready,
   output scrub_mem_pkg::ddr_chan_vec_t scrub_req_valid,
   output scrub_mem_pkg::ddr_addr_t     scrub_req_addr [`NUM_DDR],
   input  scrub_mem_pkg::ddr_chan_vec_t scrub_req_ready,

   // Debug IDs
   output scrub_reg_pkg::reg_word_t     cl_id0,
   output scrub_reg_pkg::reg_word_t     cl_id1
);

   scrub_mem_pkg::ddr_chan_vec_t scrub_en;
   scrub_mem_pkg::ddr_chan_vec_t scrub_done;
   scrub_mem_pkg::ddr_addr_t     cur_addr [`NUM_DDR];
   scrub_reg_pkg::reg_word_t     status_word;
   scrub_reg_pkg::dbg_sel_t      dbg_sel;
   logic                         dbg_en;

   // ----------------------------------------
   // Register block
   // ----------------------------------------

   scrub_ctrl_regs u_regs (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .status_word (status_word),
      .scrub_en    (scrub_en),
      .dbg_en      (dbg_en),
      .dbg_sel     (dbg_sel)
   );

   // ----------------------------------------
   // Scrubbers
   // ----------------------------------------

   for (genvar i = 0; i < `NUM_DDR; i++) begin : g_scrub
      ddr_scrubber u_scrub (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (scrub_en[i]),
         .ddr_ready  (ddr_is_ready[i]),
         .req_valid  (scrub_req_valid[i]),
         .req_addr   (scrub_req_addr[i]),
         .req_ready  (scrub_req_ready[i]),
         .done       (scrub_done[i]),
         .cur_addr   (cur_addr[i])
      );
   end

   // Status word and ID outputs
   scrub_status u_status (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .done        (scrub_done),
      .ddr_ready   (ddr_is_ready),
      .cur_addr    (cur_addr),
      .dbg_en      (dbg_en),
      .dbg_sel     (dbg_sel),
      .status_word (status_word),
      .cl_id0      (cl_id0),
      .cl_id1      (cl_id1)
   );

endmodule

//--- test/tb_clock_gen.sv
// Testbench clock and reset source
//   free-running clock
//   active-low reset held for a fixed number of cycles

`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic sync_rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Released just after a rising edge
   initial begin
      sync_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      sync_rst_n = 1'b1;
   end

endmodule

//--- test/scrub_tb.sv
// Testbench of the DDR scrubber top level
//   step table of APB accesses, ready changes and checks
//   APB master, random memory back-pressure, request monitor
//   compare task and watchdog

`timescale 1ns/100ps

`include "scrub_settings.svh"

module scrub_tb;

   localparam int ST_WRITE = 0;
   localparam int ST_READ  = 1;
   localparam int ST_WAIT  = 2;
   localparam int ST_READY = 3;
   localparam int ST_ID    = 4;
   localparam int ST_COUNT = 5;

   localparam int DRIVE_DLY  = 1;
   localparam int WAIT_BOUND = 400;

   localparam scrub_mem_pkg::ddr_addr_t BURST_BYTES =
      scrub_mem_pkg::ddr_addr_t'((`SCRB_BURST_LEN_MINUS1 + 1) * `SCRB_BEAT_BYTES);
   localparam int BURSTS = int'((`SCRB_MAX_ADDR + 64'd1) / BURST_BYTES);
   localparam scrub_reg_pkg::reg_word_t LAST_ADDR =
      scrub_reg_pkg::reg_word_t'(BURST_BYTES) * scrub_reg_pkg::reg_word_t'(BURSTS - 1);

   // One table entry
   // Data also carries a ready vector, done mask or ID word
   typedef struct {
      int                        kind;
      scrub_reg_pkg::apb_addr_t  addr;
      scrub_reg_pkg::reg_word_t  data;
      scrub_reg_pkg::reg_word_t  exp_rd;
      logic                      exp_err;
   } step_t;

   logic                         clk;
   logic                         sync_rst_n;
   scrub_reg_pkg::apb_addr_t     paddr;
   logic                         psel;
   logic                         penable;
   logic                         pwrite;
   scrub_reg_pkg::reg_word_t     pwdata;
   scrub_reg_pkg::reg_word_t     prdata;
   logic                         pready;
   logic                         pslverr;
   scrub_mem_pkg::ddr_chan_vec_t ddr_is_ready;
   scrub_mem_pkg::ddr_chan_vec_t scrub_req_valid;
   scrub_mem_pkg::ddr_addr_t     scrub_req_addr [`NUM_DDR];
   scrub_mem_pkg::ddr_chan_vec_t scrub_req_ready;
   scrub_reg_pkg::reg_word_t     cl_id0;
   scrub_reg_pkg::reg_word_t     cl_id1;

   step_t                        steps[$];
   logic                         table_ready;
   scrub_reg_pkg::reg_word_t     shadow_ctl;
   scrub_mem_pkg::ddr_addr_t     exp_addr [`NUM_DDR];
   int                           accept_cnt [`NUM_DDR];

   tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(5)) u_clk (
      .clk        (clk),
      .sync_rst_n (sync_rst_n)
   );

   ddr_scrub_top UUT (
      .clk             (clk),
      .sync_rst_n      (sync_rst_n),
      .paddr           (paddr),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .pwdata          (pwdata),
      .prdata          (prdata),
      .pready          (pready),
      .pslverr         (pslverr),
      .ddr_is_ready    (ddr_is_ready),
      .scrub_req_valid (scrub_req_valid),
      .scrub_req_addr  (scrub_req_addr),
      .scrub_req_ready (scrub_req_ready),
      .cl_id0          (cl_id0),
      .cl_id1          (cl_id1)
   );

   // ----------------------------------------
   // Helpers
   // ----------------------------------------

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   function automatic scrub_reg_pkg::reg_word_t ctl_word(input logic dbg, input int sel,
                                                         input int en);
      scrub_reg_pkg::reg_word_t w;
      w = '0;
      w[`CTL_DBG_EN_BIT] = dbg;
      w[`CTL_DBG_SEL_LSB +: 3] = 3'(sel);
      w[`NUM_DDR-1:0] = `NUM_DDR'(en);
      return w;
   endfunction

   // Done bits low and ready bits from 16 up
   function automatic scrub_reg_pkg::reg_word_t status_of(input int ready, input int done);
      scrub_reg_pkg::reg_word_t w;
      w = '0;
      w[16 +: `NUM_DDR] = `NUM_DDR'(ready);
      w[`NUM_DDR-1:0] = `NUM_DDR'(done);
      return w;
   endfunction

   task automatic add_step(input int kind, input scrub_reg_pkg::apb_addr_t addr,
                           input scrub_reg_pkg::reg_word_t data,
                           input scrub_reg_pkg::reg_word_t exp_rd, input logic exp_err);
      step_t s;
      s.kind    = kind;
      s.addr    = addr;
      s.data    = data;
      s.exp_rd  = exp_rd;
      s.exp_err = exp_err;
      steps.push_back(s);
   endtask

   // One APB transfer with setup and access phases and no wait states
   task automatic apb_access(input logic wr, input scrub_reg_pkg::apb_addr_t addr,
                             input scrub_reg_pkg::reg_word_t data,
                             output scrub_reg_pkg::reg_word_t rdata, output logic err);
      @(posedge clk);
      #DRIVE_DLY;
      paddr   = addr;
      pwrite  = wr;
      pwdata  = data;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #DRIVE_DLY;
      penable = 1'b1;
      @(negedge clk);
      check_value("pready in access phase", 64'(pready), 64'd1);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #DRIVE_DLY;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // Poll STATUS until the done bits match within a cycle bound
   task automatic wait_for_done(input scrub_mem_pkg::ddr_chan_vec_t want);
      scrub_reg_pkg::reg_word_t rd;
      logic                     err;
      int                       cycles;
      logic                     seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen) begin
         apb_access(1'b0, `REG_STATUS_OFS, '0, rd, err);
         cycles += 3;
         if (rd[`NUM_DDR-1:0] == want) begin
            seen = 1'b1;
         end else if (cycles > WAIT_BOUND) begin
            $display("Done bits stayed at %b instead of %b", rd[`NUM_DDR-1:0], want);
            abort_run();
         end
      end
   endtask

   // ----------------------------------------
   // Step table
   // ----------------------------------------

   task automatic build_table();
      add_step(ST_READ,  `REG_CTL_OFS, '0, '0, 1'b0);
      // Register access and unmapped offset
      add_step(ST_WRITE, `REG_CTL_OFS, 32'h1234_5670, '0, 1'b0);
      add_step(ST_READ,  `REG_CTL_OFS, '0, 32'h1234_5670, 1'b0);
      add_step(ST_WRITE, 8'h10, 32'hFFFF_FFFF, '0, 1'b1);
      add_step(ST_READ,  8'h10, '0, '0, 1'b1);
      add_step(ST_READ,  `REG_CTL_OFS, '0, 32'h1234_5670, 1'b0);
      add_step(ST_WRITE, `REG_CTL_OFS, '0, '0, 1'b0);
      // Ch2 enabled without ready memory while ch1 and ch3 are ready but disabled
      add_step(ST_READY, '0, 32'hB, '0, 1'b0);
      add_step(ST_WRITE, `REG_CTL_OFS, ctl_word(1'b0, 0, 'h5), '0, 1'b0);
      add_step(ST_WAIT,  '0, 32'h1, '0, 1'b0);
      add_step(ST_READ,  `REG_STATUS_OFS, '0, status_of('hB, 'h1), 1'b0);
      add_step(ST_COUNT, '0, 32'h1, '0, 1'b0);
      // Debug view of the scrub address
      add_step(ST_WRITE, `REG_CTL_OFS, ctl_word(1'b1, 0, 'h5), '0, 1'b0);
      add_step(ST_ID,    '0, LAST_ADDR, '0, 1'b0);
      add_step(ST_WRITE, `REG_CTL_OFS, ctl_word(1'b1, 5, 'h5), '0, 1'b0);
      add_step(ST_ID,    '0, LAST_ADDR, '0, 1'b0);
      add_step(ST_WRITE, `REG_CTL_OFS, ctl_word(1'b1, 2, 'h5), '0, 1'b0);
      add_step(ST_ID,    '0, '0, '0, 1'b0);
      add_step(ST_WRITE, `REG_CTL_OFS, ctl_word(1'b0, 0, 'h5), '0, 1'b0);
      add_step(ST_ID,    '0, `CL_ID0, `CL_ID1, 1'b0);
      // Stop and restart channel 0
      add_step(ST_WRITE, `REG_CTL_OFS, ctl_word(1'b0, 0, 'h4), '0, 1'b0);
      add_step(ST_READ,  `REG_STATUS_OFS, '0, status_of('hB, 'h0), 1'b0);
      add_step(ST_WRITE, `REG_CTL_OFS, ctl_word(1'b0, 0, 'h5), '0, 1'b0);
      add_step(ST_WAIT,  '0, 32'h1, '0, 1'b0);
      add_step(ST_COUNT, '0, 32'h1, '0, 1'b0);
      // Ch2 starts once its memory is ready and ch1 once it is enabled
      add_step(ST_READY, '0, 32'hF, '0, 1'b0);
      add_step(ST_WRITE, `REG_CTL_OFS, ctl_word(1'b0, 0, 'h7), '0, 1'b0);
      add_step(ST_WAIT,  '0, 32'h7, '0, 1'b0);
      add_step(ST_READ,  `REG_STATUS_OFS, '0, status_of('hF, 'h7), 1'b0);
      add_step(ST_COUNT, '0, 32'h7, '0, 1'b0);
      add_step(ST_WRITE, `REG_CTL_OFS, '0, '0, 1'b0);
      add_step(ST_READ,  `REG_STATUS_OFS, '0, status_of('hF, 'h0), 1'b0);
   endtask

   task automatic run_step(input int n);
      step_t                    s;
      scrub_reg_pkg::reg_word_t rd;
      logic                     err;
      s = steps[n];
      case (s.kind)
         ST_WRITE, ST_READ: begin
            apb_access(s.kind == ST_WRITE, s.addr, s.data, rd, err);
            check_value($sformatf("step %0d prdata", n), 64'(rd), 64'(s.exp_rd));
            check_value($sformatf("step %0d pslverr", n), 64'(err), 64'(s.exp_err));
            if (s.kind == ST_WRITE && !s.exp_err && s.addr == `REG_CTL_OFS) begin
               shadow_ctl = s.data;
            end
         end
         ST_WAIT: begin
            wait_for_done(s.data[`NUM_DDR-1:0]);
         end
         ST_READY: begin
            @(posedge clk);
            #DRIVE_DLY;
            ddr_is_ready = s.data[`NUM_DDR-1:0];
         end
         ST_ID: begin
            // Control register to ID registers takes one more clock
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_value($sformatf("step %0d cl_id0", n), 64'(cl_id0), 64'(s.data));
            check_value($sformatf("step %0d cl_id1", n), 64'(cl_id1), 64'(s.exp_rd));
         end
         ST_COUNT: begin
            for (int i = 0; i < `NUM_DDR; i++) begin
               check_value($sformatf("step %0d channel %0d burst count", n, i),
                           64'(accept_cnt[i]), s.data[i] ? 64'(BURSTS) : 64'd0);
            end
         end
         default: begin
            $display("Step %0d has an unknown kind %0d", n, s.kind);
            abort_run();
         end
      endcase
   endtask

   // ----------------------------------------
   // Memory model and request monitor
   // ----------------------------------------

   always @(posedge clk) begin
      #DRIVE_DLY;
      scrub_req_ready = `NUM_DDR'($urandom);
   end

   // Counters restart while a channel is disabled
   always @(negedge clk) begin
      if (sync_rst_n) begin
         for (int i = 0; i < `NUM_DDR; i++) begin
            if (!shadow_ctl[i]) begin
               check_value($sformatf("channel %0d request while disabled", i),
                           64'(scrub_req_valid[i]), 64'd0);
               exp_addr[i]   = '0;
               accept_cnt[i] = 0;
            end else if (scrub_req_valid[i] && scrub_req_ready[i]) begin
               check_value($sformatf("channel %0d request count in range", i),
                           64'(accept_cnt[i] < BURSTS), 64'd1);
               check_value($sformatf("channel %0d accepted address", i),
                           scrub_req_addr[i], exp_addr[i]);
               exp_addr[i]   = exp_addr[i] + BURST_BYTES;
               accept_cnt[i] = accept_cnt[i] + 1;
            end
         end
      end
   end

   // ----------------------------------------
   // Main sequence and watchdog
   // ----------------------------------------

   initial begin
      void'($urandom(97));
      paddr           = '0;
      psel            = 1'b0;
      penable         = 1'b0;
      pwrite          = 1'b0;
      pwdata          = '0;
      ddr_is_ready    = '0;
      scrub_req_ready = '0;
      shadow_ctl      = '0;
      table_ready     = 1'b0;
      build_table();
      table_ready = 1'b1;
      wait (sync_rst_n === 1'b1);
      @(negedge clk);
      check_value("valid after reset", 64'(scrub_req_valid), 64'd0);
      check_value("cl_id0 after reset", 64'(cl_id0), 64'(`CL_ID0));
      check_value("cl_id1 after reset", 64'(cl_id1), 64'(`CL_ID1));
      for (int n = 0; n < steps.size(); n++) begin
         run_step(n);
      end
      $display("all tests passed");
      $finish;
   end

   initial begin
      int limit;
      wait (table_ready);
      limit = (steps.size() + BURSTS * `NUM_DDR) * 20;
      repeat (limit) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not finish", limit);
      abort_run();
   end

endmodule

//--- compile.f
+incdir+source
source/scrub_mem_pkg.sv
source/scrub_reg_pkg.sv
source/scrub_ctrl_regs.sv
source/ddr_scrubber.sv
source/scrub_status.sv
source/ddr_scrub_top.sv
test/tb_clock_gen.sv
test/scrub_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the scrubber testbench with Verilator.
# The exit status is nonzero if the build fails or the testbench stops on an error.

cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module scrub_tb -o scrub_sim &&
./obj_dir/scrub_sim ||
{ echo "simulation failed"; exit 1; }
